// File: design/mips_id_pkg.sv
package mips_id_pkg;

    localparam int xlen_w     = 32;
    localparam int reg_addr_w = 5;

    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [xlen_w-1:0]     word_t;

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // function codes under op_special
    localparam logic [5:0] fn_sll     = 6'h00;
    localparam logic [5:0] fn_srl     = 6'h02;
    localparam logic [5:0] fn_sra     = 6'h03;
    localparam logic [5:0] fn_jr      = 6'h08;
    localparam logic [5:0] fn_syscall = 6'h0c;
    localparam logic [5:0] fn_break   = 6'h0d;
    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_subu    = 6'h23;
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_xor     = 6'h26;
    localparam logic [5:0] fn_nor     = 6'h27;
    localparam logic [5:0] fn_slt     = 6'h2a;
    localparam logic [5:0] fn_sltu    = 6'h2b;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_or, alu_xor, alu_nor,
        alu_sll, alu_srl, alu_sra, alu_lui,
        alu_none
    } alu_op_t;

    typedef enum logic [2:0] {
        br_none, br_beq, br_bne, br_j, br_jal, br_jr
    } br_kind_t;

    typedef enum logic [1:0] {
        exc_none, exc_ri, exc_sys, exc_bp
    } exc_code_t;

    typedef enum logic [1:0] {src1_reg, src1_shamt, src1_pc} src1_sel_t;
    typedef enum logic [1:0] {src2_reg, src2_imm, src2_eight} src2_sel_t;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_to_id_t;

    typedef struct packed {
        reg_addr_t dest;     // 0 when the stage writes nothing
        word_t     result;
        logic      is_load;
    } fwd_src_t;

    typedef struct packed {
        alu_op_t   alu_op;
        word_t     src1;
        word_t     src2;
        word_t     store_data;
        reg_addr_t dest;
        logic      gr_we;
        logic      mem_we;
        logic      load_op;
        br_kind_t  br_kind;
        word_t     br_target;
        exc_code_t exc_code;
        word_t     pc;
    } id_to_ex_t;

    typedef struct packed {
        alu_op_t   alu_op;
        reg_addr_t dest;
        logic      gr_we;
        logic      mem_we;
        logic      load_op;
        br_kind_t  br_kind;
        exc_code_t exc_code;
        word_t     imm_value;
        src1_sel_t src1_sel;
        src2_sel_t src2_sel;
        logic      rs_used;
        logic      rt_used;
    } decode_t;

endpackage

// File: design/inst_decoder.sv
module inst_decoder (
    input  mips_id_pkg::word_t   inst,
    output mips_id_pkg::decode_t dec
);
    import mips_id_pkg::*;

    logic [5:0] op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] sa;
    logic [5:0] func;
    word_t      imm_sext;
    word_t      imm_zext;
    logic       defined;
    logic       is_sys;
    logic       is_brk;
    logic       imm_form;    // rs op imm -> rt
    logic       use_zext;

    // R-type function to ALU op
    function automatic alu_op_t func_alu_op(input logic [5:0] fn);
        case (fn)
            fn_addu: return alu_add;
            fn_subu: return alu_sub;
            fn_slt:  return alu_slt;
            fn_sltu: return alu_sltu;
            fn_and:  return alu_and;
            fn_or:   return alu_or;
            fn_xor:  return alu_xor;
            fn_nor:  return alu_nor;
            fn_sll:  return alu_sll;
            fn_srl:  return alu_srl;
            fn_sra:  return alu_sra;
            default: return alu_none;
        endcase
    endfunction

    assign op       = inst[31:26];
    assign rs       = inst[25:21];
    assign rt       = inst[20:16];
    assign rd       = inst[15:11];
    assign sa       = inst[10:6];
    assign func     = inst[5:0];
    assign imm_sext = {{16{inst[15]}}, inst[15:0]};
    assign imm_zext = {16'b0, inst[15:0]};

    always_comb begin
        defined      = 1'b0;
        is_sys       = 1'b0;
        is_brk       = 1'b0;
        imm_form     = 1'b0;
        use_zext     = 1'b0;
        dec.alu_op   = alu_none;
        dec.dest     = '0;
        dec.mem_we   = 1'b0;
        dec.load_op  = 1'b0;
        dec.br_kind  = br_none;
        dec.src1_sel = src1_reg;
        dec.src2_sel = src2_reg;
        dec.rs_used  = 1'b0;
        dec.rt_used  = 1'b0;
        case (op)
            op_special: begin
                case (func)
                    fn_addu, fn_subu, fn_slt, fn_sltu, fn_and, fn_or, fn_xor, fn_nor: begin
                        if (sa == 5'd0) begin       // shamt field must be zero
                            defined     = 1'b1;
                            dec.alu_op  = func_alu_op(func);
                            dec.dest    = rd;
                            dec.rs_used = 1'b1;
                            dec.rt_used = 1'b1;
                        end
                    end
                    fn_sll, fn_srl, fn_sra: begin
                        if (rs == 5'd0) begin
                            defined      = 1'b1;
                            dec.alu_op   = func_alu_op(func);
                            dec.dest     = rd;
                            dec.src1_sel = src1_shamt;
                            dec.rt_used  = 1'b1;
                        end
                    end
                    fn_jr: begin
                        if (rt == 5'd0 && rd == 5'd0 && sa == 5'd0) begin
                            defined     = 1'b1;
                            dec.br_kind = br_jr;
                            dec.rs_used = 1'b1;
                        end
                    end
                    fn_syscall: begin
                        defined = 1'b1;
                        is_sys  = 1'b1;
                    end
                    fn_break: begin
                        defined = 1'b1;
                        is_brk  = 1'b1;
                    end
                    default: ;
                endcase
            end
            op_j: begin
                defined     = 1'b1;
                dec.br_kind = br_j;
            end
            op_jal: begin
                defined      = 1'b1;
                dec.br_kind  = br_jal;
                dec.alu_op   = alu_add;             // link value pc + 8
                dec.src1_sel = src1_pc;
                dec.src2_sel = src2_eight;
                dec.dest     = 5'd31;
            end
            op_beq, op_bne: begin
                defined     = 1'b1;
                dec.br_kind = (op == op_beq) ? br_beq : br_bne;
                dec.rs_used = 1'b1;
                dec.rt_used = 1'b1;
            end
            op_addiu: begin
                imm_form   = 1'b1;
                dec.alu_op = alu_add;
            end
            op_slti: begin
                imm_form   = 1'b1;
                dec.alu_op = alu_slt;
            end
            op_sltiu: begin
                imm_form   = 1'b1;
                dec.alu_op = alu_sltu;
            end
            op_andi: begin
                imm_form   = 1'b1;
                use_zext   = 1'b1;
                dec.alu_op = alu_and;
            end
            op_ori: begin
                imm_form   = 1'b1;
                use_zext   = 1'b1;
                dec.alu_op = alu_or;
            end
            op_xori: begin
                imm_form   = 1'b1;
                use_zext   = 1'b1;
                dec.alu_op = alu_xor;
            end
            op_lui: begin
                if (rs == 5'd0) begin
                    defined      = 1'b1;
                    use_zext     = 1'b1;
                    dec.alu_op   = alu_lui;
                    dec.src2_sel = src2_imm;
                    dec.dest     = rt;
                end
            end
            op_lw: begin
                imm_form    = 1'b1;
                dec.alu_op  = alu_add;              // address calc
                dec.load_op = 1'b1;
            end
            op_sw: begin
                defined      = 1'b1;
                dec.alu_op   = alu_add;
                dec.src2_sel = src2_imm;
                dec.mem_we   = 1'b1;
                dec.rs_used  = 1'b1;
                dec.rt_used  = 1'b1;                // store data
            end
            default: ;
        endcase

        if (imm_form) begin
            defined      = 1'b1;
            dec.dest     = rt;
            dec.src2_sel = src2_imm;
            dec.rs_used  = 1'b1;
        end

        dec.imm_value = use_zext ? imm_zext : imm_sext;
        dec.gr_we     = (dec.dest != 5'd0);

        if (!defined)
            dec.exc_code = exc_ri;
        else if (is_sys)
            dec.exc_code = exc_sys;
        else if (is_brk)
            dec.exc_code = exc_bp;
        else
            dec.exc_code = exc_none;
    end

endmodule

// File: design/reg_file.sv
module reg_file (
    input  logic                   clk,
    input  logic                   reset,
    input  mips_id_pkg::reg_addr_t raddr1,
    input  mips_id_pkg::reg_addr_t raddr2,
    input  mips_id_pkg::fwd_src_t  wr,
    output mips_id_pkg::word_t     rdata1,
    output mips_id_pkg::word_t     rdata2
);
    import mips_id_pkg::*;

    word_t regs [32];
    logic  wr_en;

    assign wr_en = (wr.dest != 5'd0);       // dest 0 means no write

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr.dest] <= wr.result;
        end
    end

    // r0 hardwired to zero
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// File: design/operand_bypass.sv
module operand_bypass (
    input  mips_id_pkg::reg_addr_t src_addr,
    input  logic                   src_used,
    input  logic                   stage_valid,
    input  mips_id_pkg::word_t     rf_data,
    input  mips_id_pkg::fwd_src_t  ex_fwd,
    input  mips_id_pkg::fwd_src_t  mem_fwd,
    input  mips_id_pkg::fwd_src_t  wb_fwd,
    output mips_id_pkg::word_t     operand,
    output logic                   load_hazard
);
    import mips_id_pkg::*;

    logic lookup;
    logic hit_ex;
    logic hit_mem;
    logic hit_wb;

    // r0 never forwarded
    assign lookup  = src_used && (src_addr != 5'd0);
    assign hit_ex  = lookup && (ex_fwd.dest == src_addr);
    assign hit_mem = lookup && (mem_fwd.dest == src_addr);
    assign hit_wb  = lookup && (wb_fwd.dest == src_addr);

    // youngest producer wins
    always_comb begin
        if (hit_ex)
            operand = ex_fwd.result;
        else if (hit_mem)
            operand = mem_fwd.result;
        else if (hit_wb)
            operand = wb_fwd.result;    // covers same-cycle rf write
        else
            operand = rf_data;
    end

    // load in EXE has no result yet
    assign load_hazard = stage_valid && hit_ex && ex_fwd.is_load;

endmodule

// File: design/id_stage_ctrl.sv
module id_stage_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      in_valid,
    input  mips_id_pkg::fetch_to_id_t in_bus,
    input  logic                      es_allowin,
    input  logic                      rs_hazard,
    input  logic                      rt_hazard,
    output logic                      ds_allowin,
    output logic                      out_valid,
    output mips_id_pkg::fetch_to_id_t stage_bus,
    output logic                      stage_valid
);
    import mips_id_pkg::*;

    logic         ready_go;
    logic         accept;
    fetch_to_id_t stage_reg;

    assign ready_go   = !(rs_hazard || rt_hazard);     // load-use stall
    assign out_valid  = stage_valid && ready_go;
    assign ds_allowin = !stage_valid || (ready_go && es_allowin);
    assign accept     = in_valid && ds_allowin && !flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else if (flush) begin
            stage_valid <= 1'b0;            // allowin ignored this cycle
        end else if (ds_allowin) begin
            stage_valid <= in_valid;
        end
    end

    // payload held while stalled or back-pressured
    always_ff @(posedge clk) begin
        if (accept) begin
            stage_reg <= in_bus;
        end
    end

    assign stage_bus = stage_reg;

endmodule

// File: design/id_stage_top.sv
module id_stage_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      in_valid,
    input  mips_id_pkg::fetch_to_id_t in_bus,
    input  logic                      es_allowin,
    input  mips_id_pkg::fwd_src_t     ex_fwd,
    input  mips_id_pkg::fwd_src_t     mem_fwd,
    input  mips_id_pkg::fwd_src_t     wb_fwd,
    output logic                      ds_allowin,
    output logic                      out_valid,
    output mips_id_pkg::id_to_ex_t    out_bus
);
    import mips_id_pkg::*;

    fetch_to_id_t stage_bus;
    logic         stage_valid;
    decode_t      dec;
    reg_addr_t    rs;
    reg_addr_t    rt;
    word_t        rf_rdata1;
    word_t        rf_rdata2;
    word_t        rs_val;
    word_t        rt_val;
    logic         rs_hazard;
    logic         rt_hazard;
    word_t        pc_plus4;
    word_t        br_target;

    assign rs = stage_bus.inst[25:21];
    assign rt = stage_bus.inst[20:16];

    id_stage_ctrl id_stage_ctrl_inst (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_bus      (in_bus),
        .es_allowin  (es_allowin),
        .rs_hazard   (rs_hazard),
        .rt_hazard   (rt_hazard),
        .ds_allowin  (ds_allowin),
        .out_valid   (out_valid),
        .stage_bus   (stage_bus),
        .stage_valid (stage_valid)
    );

    inst_decoder inst_decoder_inst (
        .inst (stage_bus.inst),
        .dec  (dec)
    );

    reg_file reg_file_inst (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (rs),
        .raddr2 (rt),
        .wr     (wb_fwd),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    operand_bypass rs_bypass_inst (
        .src_addr    (rs),
        .src_used    (dec.rs_used),
        .stage_valid (stage_valid),
        .rf_data     (rf_rdata1),
        .ex_fwd      (ex_fwd),
        .mem_fwd     (mem_fwd),
        .wb_fwd      (wb_fwd),
        .operand     (rs_val),
        .load_hazard (rs_hazard)
    );

    operand_bypass rt_bypass_inst (
        .src_addr    (rt),
        .src_used    (dec.rt_used),
        .stage_valid (stage_valid),
        .rf_data     (rf_rdata2),
        .ex_fwd      (ex_fwd),
        .mem_fwd     (mem_fwd),
        .wb_fwd      (wb_fwd),
        .operand     (rt_val),
        .load_hazard (rt_hazard)
    );

    assign pc_plus4 = stage_bus.pc + 32'd4;

    always_comb begin
        case (dec.br_kind)
            br_j, br_jal: br_target = {pc_plus4[31:28], stage_bus.inst[25:0], 2'b00};
            br_jr:        br_target = rs_val;     // forwarded rs
            default:      br_target = pc_plus4 + {dec.imm_value[29:0], 2'b00};
        endcase
    end

    always_comb begin
        out_bus.alu_op = dec.alu_op;
        case (dec.src1_sel)
            src1_shamt: out_bus.src1 = {27'b0, stage_bus.inst[10:6]};
            src1_pc:    out_bus.src1 = stage_bus.pc;
            default:    out_bus.src1 = rs_val;
        endcase
        case (dec.src2_sel)
            src2_imm:   out_bus.src2 = dec.imm_value;
            src2_eight: out_bus.src2 = 32'd8;       // jal link offset
            default:    out_bus.src2 = rt_val;
        endcase
        out_bus.store_data = rt_val;
        out_bus.dest       = dec.dest;
        out_bus.gr_we      = dec.gr_we;
        out_bus.mem_we     = dec.mem_we;
        out_bus.load_op    = dec.load_op;
        out_bus.br_kind    = dec.br_kind;
        out_bus.br_target  = br_target;
        out_bus.exc_code   = dec.exc_code;
        out_bus.pc         = stage_bus.pc;
    end

endmodule

// File: dv/id_stage_tb.sv
module id_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import mips_id_pkg::*;

    localparam int preload_cycles = 36;     // reset, 31 writes, bus clear
    localparam int chk_w          = $bits(id_to_ex_t);

    typedef struct {
        word_t     inst;
        word_t     pc;
        fwd_src_t  ex;
        fwd_src_t  mem;
        fwd_src_t  wb;
        logic      es_allowin;
        logic      flush;
        int        hold;                    // cycles of stall or back-pressure
        logic      exp_stall;
        logic      chk_srcs;
        logic      chk_store;
        logic      chk_target;
        id_to_ex_t exp;
    } entry_t;

    logic         clk;
    logic         reset;
    logic         flush;
    logic         in_valid;
    fetch_to_id_t in_bus;
    logic         es_allowin;
    fwd_src_t     ex_fwd;
    fwd_src_t     mem_fwd;
    fwd_src_t     wb_fwd;
    logic         ds_allowin;
    logic         out_valid;
    id_to_ex_t    out_bus;

    entry_t stim_q [$];
    word_t  sh [32];                        // shadow of the register file
    word_t  preload_val [32];
    word_t  next_pc;
    int     cycles;
    int     timeout_limit;

    id_stage_top id_stage_top_inst (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_bus     (in_bus),
        .es_allowin (es_allowin),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .ds_allowin (ds_allowin),
        .out_valid  (out_valid),
        .out_bus    (out_bus)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit)
            abort_run($sformatf("timeout: run did not finish within %0d cycles", timeout_limit));
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t r_type(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input logic [4:0] sa,
                                     input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t i_type(input logic [5:0] op, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_type(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    function automatic fwd_src_t fwd(input reg_addr_t dest, input word_t result,
                                     input logic is_load);
        fwd_src_t f;
        f.dest    = dest;
        f.result  = result;
        f.is_load = is_load;
        return f;
    endfunction

    function automatic entry_t blank_entry(input word_t inst);
        entry_t e;
        e.inst       = inst;
        e.pc         = '0;
        e.ex         = '0;
        e.mem        = '0;
        e.wb         = '0;
        e.es_allowin = 1'b1;
        e.flush      = 1'b0;
        e.hold       = 0;
        e.exp_stall  = 1'b0;
        e.chk_srcs   = 1'b0;
        e.chk_store  = 1'b0;
        e.chk_target = 1'b0;
        e.exp        = '0;
        e.exp.alu_op = alu_none;
        return e;
    endfunction

    function automatic entry_t alu_entry(input word_t inst, input alu_op_t op,
                                         input reg_addr_t dest, input word_t s1,
                                         input word_t s2);
        entry_t e;
        e            = blank_entry(inst);
        e.exp.alu_op = op;
        e.exp.dest   = dest;
        e.exp.gr_we  = (dest != 5'd0);
        e.exp.src1   = s1;
        e.exp.src2   = s2;
        e.chk_srcs   = 1'b1;
        return e;
    endfunction

    function automatic entry_t ctrl_entry(input word_t inst, input br_kind_t br,
                                          input word_t target, input exc_code_t exc);
        entry_t e;
        e              = blank_entry(inst);
        e.exp.br_kind  = br;
        e.exp.br_target = target;
        e.exp.exc_code = exc;
        e.chk_target   = (br != br_none);
        return e;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [chk_w-1:0] got,
                                   input logic [chk_w-1:0] exp);
        abort_run($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic check_field(input string name, input logic [chk_w-1:0] got,
                               input logic [chk_w-1:0] exp);
        assert (got === exp)
        else report_mismatch(name, got, exp);
    endtask

    // wb write of an entry lands in the register file
    task automatic push_entry(input entry_t e);
        e.pc     = next_pc;
        e.exp.pc = next_pc;
        next_pc  = next_pc + 32'd4;
        if (e.wb.dest != 5'd0)
            sh[e.wb.dest] = e.wb.result;
        stim_q.push_back(e);
    endtask

    task automatic make_shadow();
        logic [31:0] seed;
        seed  = 32'h5476eb4a;
        sh[0] = '0;
        for (int i = 1; i < 32; i++) begin
            seed           = lcg_next(seed);
            sh[i]          = seed;
            preload_val[i] = seed;
        end
    endtask

    task automatic build_table();
        entry_t e;
        word_t  p4;
        // R-type and shifts
        e = alu_entry(r_type(5'd1, 5'd2, 5'd3, 5'd0, fn_addu), alu_add, 5'd3, sh[1], sh[2]);
        push_entry(e);
        e = alu_entry(r_type(5'd5, 5'd6, 5'd4, 5'd0, fn_subu), alu_sub, 5'd4, sh[5], sh[6]);
        push_entry(e);
        e = alu_entry(r_type(5'd8, 5'd9, 5'd7, 5'd0, fn_slt), alu_slt, 5'd7, sh[8], sh[9]);
        push_entry(e);
        e = alu_entry(r_type(5'd11, 5'd12, 5'd10, 5'd0, fn_nor), alu_nor, 5'd10, sh[11], sh[12]);
        push_entry(e);
        e = alu_entry(r_type(5'd0, 5'd14, 5'd13, 5'd5, fn_sll), alu_sll, 5'd13, 32'd5, sh[14]);
        push_entry(e);
        e = alu_entry(r_type(5'd0, 5'd16, 5'd15, 5'd31, fn_sra), alu_sra, 5'd15, 32'd31, sh[16]);
        push_entry(e);
        e = alu_entry(r_type(5'd0, 5'd18, 5'd20, 5'd1, fn_srl), alu_srl, 5'd20, 32'd1, sh[18]);
        push_entry(e);
        // immediate and memory forms
        e = alu_entry(i_type(op_addiu, 5'd18, 5'd17, 16'h8001), alu_add, 5'd17, sh[18],
                      32'hffff_8001);
        push_entry(e);
        e = alu_entry(i_type(op_andi, 5'd20, 5'd19, 16'h8001), alu_and, 5'd19, sh[20],
                      32'h0000_8001);
        push_entry(e);
        e = alu_entry(i_type(op_slti, 5'd2, 5'd9, 16'hfff0), alu_slt, 5'd9, sh[2], 32'hffff_fff0);
        push_entry(e);
        e = alu_entry(i_type(op_lui, 5'd0, 5'd21, 16'h1234), alu_lui, 5'd21, 32'd0, 32'h1234);
        push_entry(e);
        e = alu_entry(i_type(op_lw, 5'd23, 5'd22, 16'h0010), alu_add, 5'd22, sh[23], 32'h10);
        e.exp.load_op = 1'b1;
        push_entry(e);
        e = alu_entry(i_type(op_sw, 5'd25, 5'd24, 16'hfffc), alu_add, 5'd0, sh[25], 32'hffff_fffc);
        e.exp.mem_we     = 1'b1;
        e.exp.store_data = sh[24];
        e.chk_store      = 1'b1;
        push_entry(e);
        // forwarding priority, EXE over MEM over WB
        e = alu_entry(r_type(5'd1, 5'd1, 5'd26, 5'd0, fn_addu), alu_add, 5'd26, 32'h1111_0001,
                      32'h1111_0001);
        e.ex  = fwd(5'd1, 32'h1111_0001, 1'b0);
        e.mem = fwd(5'd1, 32'h2222_0001, 1'b0);
        e.wb  = fwd(5'd1, 32'h3333_0001, 1'b0);
        push_entry(e);
        e = alu_entry(r_type(5'd2, 5'd2, 5'd27, 5'd0, fn_addu), alu_add, 5'd27, 32'h2222_0002,
                      32'h2222_0002);
        e.mem = fwd(5'd2, 32'h2222_0002, 1'b0);
        e.wb  = fwd(5'd2, 32'h3333_0002, 1'b0);
        push_entry(e);
        e = alu_entry(r_type(5'd0, 5'd3, 5'd28, 5'd0, fn_or), alu_or, 5'd28, 32'd0, 32'h3333_0003);
        e.ex = fwd(5'd0, 32'hdead_beef, 1'b0);          // r0 never takes a bus value
        e.wb = fwd(5'd3, 32'h3333_0003, 1'b0);
        push_entry(e);
        // load-use stalls, then MEM or WB supplies the value
        e = alu_entry(r_type(5'd4, 5'd5, 5'd29, 5'd0, fn_addu), alu_add, 5'd29, 32'h2222_0004,
                      sh[5]);
        e.ex        = fwd(5'd4, 32'h1111_0004, 1'b1);
        e.mem       = fwd(5'd4, 32'h2222_0004, 1'b0);
        e.hold      = 3;
        e.exp_stall = 1'b1;
        push_entry(e);
        e = alu_entry(i_type(op_sw, 5'd7, 5'd6, 16'h0008), alu_add, 5'd0, sh[7], 32'h8);
        e.exp.mem_we     = 1'b1;
        e.exp.store_data = 32'h3333_0006;
        e.chk_store      = 1'b1;
        e.ex             = fwd(5'd6, 32'h1111_0006, 1'b1);
        e.wb             = fwd(5'd6, 32'h3333_0006, 1'b0);
        e.hold           = 2;
        e.exp_stall      = 1'b1;
        push_entry(e);
        // load in EXE targets a register the instruction does not read
        e = alu_entry(i_type(op_ori, 5'd8, 5'd10, 16'h00ff), alu_or, 5'd10, sh[8], 32'hff);
        e.ex = fwd(5'd10, 32'h1111_000a, 1'b1);
        push_entry(e);
        // back-pressure and flush
        e = alu_entry(r_type(5'd8, 5'd9, 5'd30, 5'd0, fn_xor), alu_xor, 5'd30, sh[8], sh[9]);
        e.es_allowin = 1'b0;
        e.hold       = 4;
        push_entry(e);
        e = alu_entry(r_type(5'd2, 5'd3, 5'd1, 5'd0, fn_addu), alu_add, 5'd1, sh[2], sh[3]);
        e.es_allowin = 1'b0;                            // stage would keep it without flush
        e.flush      = 1'b1;
        push_entry(e);
        // branches and jumps
        p4 = next_pc + 32'd4;
        e = ctrl_entry(i_type(op_beq, 5'd10, 5'd11, 16'hfffe), br_beq, p4 - 32'd8, exc_none);
        push_entry(e);
        p4 = next_pc + 32'd4;
        e = ctrl_entry(i_type(op_bne, 5'd12, 5'd13, 16'h0010), br_bne, p4 + 32'h40, exc_none);
        push_entry(e);
        p4 = next_pc + 32'd4;
        e = ctrl_entry(j_type(op_j, 26'h012_3456), br_j, {p4[31:28], 26'h012_3456, 2'b00},
                       exc_none);
        push_entry(e);
        p4 = next_pc + 32'd4;
        e = ctrl_entry(j_type(op_jal, 26'h023_4567), br_jal, {p4[31:28], 26'h023_4567, 2'b00},
                       exc_none);
        e.exp.alu_op = alu_add;                         // link address pc + 8
        e.exp.dest   = 5'd31;
        e.exp.gr_we  = 1'b1;
        e.exp.src1   = next_pc;
        e.exp.src2   = 32'd8;
        e.chk_srcs   = 1'b1;
        push_entry(e);
        e = ctrl_entry(r_type(5'd14, 5'd0, 5'd0, 5'd0, fn_jr), br_jr, sh[14], exc_none);
        push_entry(e);
        // exceptions
        e = ctrl_entry({6'h3f, 26'h0}, br_none, 32'd0, exc_ri);
        push_entry(e);
        e = ctrl_entry(r_type(5'd1, 5'd2, 5'd3, 5'd4, fn_addu), br_none, 32'd0, exc_ri);
        push_entry(e);
        e = ctrl_entry(r_type(5'd0, 5'd0, 5'd0, 5'd0, fn_syscall), br_none, 32'd0, exc_sys);
        push_entry(e);
        e = ctrl_entry(r_type(5'd0, 5'd0, 5'd0, 5'd0, fn_break), br_none, 32'd0, exc_bp);
        push_entry(e);
    endtask

    task automatic preload_regs();
        for (int i = 1; i < 32; i++) begin
            @(posedge clk);
            wb_fwd <= fwd(5'(i), preload_val[i], 1'b0);
        end
        @(posedge clk);
        wb_fwd <= '0;
    endtask

    task automatic check_outputs(input entry_t e);
        check_field("out_valid", out_valid, 1'b1);
        check_field("out_bus.pc", out_bus.pc, e.exp.pc);
        check_field("out_bus.alu_op", out_bus.alu_op, e.exp.alu_op);
        check_field("out_bus.dest", out_bus.dest, e.exp.dest);
        check_field("out_bus.gr_we", out_bus.gr_we, e.exp.gr_we);
        check_field("out_bus.mem_we", out_bus.mem_we, e.exp.mem_we);
        check_field("out_bus.load_op", out_bus.load_op, e.exp.load_op);
        check_field("out_bus.br_kind", out_bus.br_kind, e.exp.br_kind);
        check_field("out_bus.exc_code", out_bus.exc_code, e.exp.exc_code);
        if (e.chk_srcs) begin
            check_field("out_bus.src1", out_bus.src1, e.exp.src1);
            check_field("out_bus.src2", out_bus.src2, e.exp.src2);
        end
        if (e.chk_store)
            check_field("out_bus.store_data", out_bus.store_data, e.exp.store_data);
        if (e.chk_target)
            check_field("out_bus.br_target", out_bus.br_target, e.exp.br_target);
    endtask

    task automatic run_entry(input entry_t e);
        id_to_ex_t held;
        @(posedge clk);
        in_valid   <= 1'b1;
        in_bus     <= {e.pc, e.inst};
        ex_fwd     <= e.ex;
        mem_fwd    <= e.mem;
        wb_fwd     <= e.wb;
        es_allowin <= e.es_allowin;
        flush      <= 1'b0;
        @(negedge clk);
        check_field("ds_allowin", ds_allowin, 1'b1);    // stage must be empty
        @(posedge clk);
        in_valid <= 1'b0;
        in_bus   <= ~{e.pc, e.inst};                    // stale bus must not be taken
        if (e.flush) begin
            flush <= 1'b1;
            @(posedge clk);
            flush <= 1'b0;
            @(negedge clk);
            check_field("out_valid", out_valid, 1'b0);
            return;
        end
        for (int i = 0; i < e.hold; i++) begin
            @(negedge clk);
            check_field("out_valid", out_valid, !e.exp_stall);
            check_field("ds_allowin", ds_allowin, 1'b0);
            if (i == 0)
                held = out_bus;
            else if (!e.exp_stall)
                check_field("out_bus", out_bus, held);  // must hold under back-pressure
            @(posedge clk);
        end
        if (e.exp_stall)
            ex_fwd <= '0;                               // load result moves on
        es_allowin <= 1'b1;
        do begin
            @(negedge clk);
        end while (!out_valid);
        check_outputs(e);
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        flush         = 1'b0;
        in_valid      = 1'b0;
        in_bus        = '0;
        es_allowin    = 1'b1;
        ex_fwd        = '0;
        mem_fwd       = '0;
        wb_fwd        = '0;
        cycles        = 0;
        next_pc       = 32'h0040_0000;
        make_shadow();
        build_table();
        timeout_limit = stim_q.size() * 20 + preload_cycles;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        preload_regs();
        foreach (stim_q[i]) begin
            run_entry(stim_q[i]);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: compile.f
design/mips_id_pkg.sv
design/inst_decoder.sv
design/reg_file.sv
design/operand_bypass.sv
design/id_stage_ctrl.sv
design/id_stage_top.sv
dv/id_stage_tb.sv

// File: Bender.yml
package:
  name: mips_id_stage

sources:
  - files:
      - design/mips_id_pkg.sv
      - design/inst_decoder.sv
      - design/reg_file.sv
      - design/operand_bypass.sv
      - design/id_stage_ctrl.sv
      - design/id_stage_top.sv
  - target: test
    files:
      - dv/id_stage_tb.sv
